// File: src/accel_pkg.sv
// Shared definitions for the vector dispatch front
// Widths, opcodes, status and operation encodings, accelerator request layout
package accel_pkg;

  localparam int XLEN          = 32;
  localparam int REG_ADDR_SIZE = 5;
  localparam logic [XLEN-1:0] BOOT_ADDR = '0;  // First fetch after reset

  localparam int REQ_DEPTH  = 4;  // Requests in flight to the accelerator
  localparam int RESP_DEPTH = 2;

  // Major opcodes
  localparam logic [6:0] OPCODE_VEC      = 7'b101_0111;
  localparam logic [6:0] OPCODE_LOAD_FP  = 7'b000_0111;
  localparam logic [6:0] OPCODE_STORE_FP = 7'b010_0111;
  localparam logic [6:0] OPCODE_AMO      = 7'b010_1111;
  localparam logic [6:0] OPCODE_SYSTEM   = 7'b111_0011;

  // Vector arithmetic func3 categories
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPFVV = 3'b001;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPFVF = 3'b101;
  localparam logic [2:0] OPMVX = 3'b110;
  localparam logic [2:0] OPCFG = 3'b111;  // vsetvli/vsetivli/vsetvl

  // mstatus.FS / mstatus.VS encoding
  typedef enum logic [1:0] {
    XS_OFF     = 2'b00,
    XS_INITIAL = 2'b01,
    XS_CLEAN   = 2'b10,
    XS_DIRTY   = 2'b11
  } xs_t;

  typedef enum logic [2:0] {
    ACCEL_OP       = 3'd0,
    ACCEL_OP_LOAD  = 3'd1,
    ACCEL_OP_STORE = 3'd2,
    ACCEL_OP_FS1   = 3'd3,  // Scalar FP source, index only
    ACCEL_OP_FD    = 3'd4   // Scalar FP destination, index only
  } accel_op_t;

  typedef struct packed {
    logic [31:0]              instr;  // Undecoded instruction word
    accel_op_t                op;
    logic                     vfp;
    logic [XLEN-1:0]          rs1;
    logic [XLEN-1:0]          rs2;
    logic [REG_ADDR_SIZE-1:0] rd;
  } accel_req_t;

  // vstart, vxsat, vxrm, vcsr, vl, vtype, vlenb
  function automatic logic is_vector_csr(logic [11:0] csr);
    case (csr)
      12'h008, 12'h009, 12'h00A, 12'h00F,
      12'hC20, 12'hC21, 12'hC22: return 1'b1;
      default:                   return 1'b0;
    endcase
  endfunction

endpackage

// File: src/wb_fetch.sv
// Instruction fetch master on a read-only Wishbone classic bus
// One word at a time, next fetch starts once the word is consumed
`timescale 1ns/1ns

module wb_fetch (
  input  logic                       clk_i,
  input  logic                       rst_i,
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic [accel_pkg::XLEN-1:0] wb_adr_o,
  input  logic [31:0]                wb_dat_i,
  input  logic                       wb_ack_i,
  output logic                       instr_valid_o,
  output logic [31:0]                instr_o,
  output logic [accel_pkg::XLEN-1:0] pc_o,
  input  logic                       instr_done_i
);

  typedef enum logic [1:0] {S_REQ, S_DELIVER, S_WAIT} state_e;

  state_e                     state_q;
  logic                       stb_q;   // Bus cycle in progress
  logic [accel_pkg::XLEN-1:0] pc_q;
  logic [31:0]                instr_q; // Fetched word, payload only

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_REQ;
      stb_q   <= 1'b0;
      pc_q    <= accel_pkg::BOOT_ADDR;
    end else begin
      case (state_q)
        S_REQ: begin
          if (!stb_q) begin
            stb_q <= 1'b1;  // First fetch after reset
          end else if (wb_ack_i) begin
            stb_q   <= 1'b0;
            state_q <= S_DELIVER;
          end
        end
        S_DELIVER: state_q <= S_WAIT;  // One-cycle valid pulse
        S_WAIT: begin
          if (instr_done_i) begin
            pc_q    <= pc_q + 32'd4;  // No branches here
            stb_q   <= 1'b1;
            state_q <= S_REQ;
          end
        end
        default: state_q <= S_REQ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_q && wb_ack_i) instr_q <= wb_dat_i;  // Capture on ack
  end

  assign wb_cyc_o      = stb_q;
  assign wb_stb_o      = stb_q;
  assign wb_adr_o      = pc_q;
  assign instr_valid_o = (state_q == S_DELIVER);
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;

  // Classic cycle, strobe held until the slave acks
  a_stb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o);

endmodule

// File: src/accel_first_pass_decoder.sv
// First-pass decoder for vector instructions
// Flags vector ops, scalar register use and accelerator operation, combinational only
`timescale 1ns/1ns

module accel_first_pass_decoder (
  input  logic [31:0]                         instruction_i,
  input  accel_pkg::xs_t                      fs_i,   // FP extension status
  input  accel_pkg::xs_t                      vs_i,   // Vector extension status
  output logic                                is_accel_o,
  output logic                                illegal_instr_o,
  output logic                                vfp_o,
  output accel_pkg::accel_op_t                op_o,
  output logic [accel_pkg::REG_ADDR_SIZE-1:0] rs1_o,
  output logic [accel_pkg::REG_ADDR_SIZE-1:0] rs2_o,
  output logic [accel_pkg::REG_ADDR_SIZE-1:0] rd_o,
  output logic                                use_rs1_o,
  output logic                                use_rs2_o,
  output logic                                use_rd_o
);

  logic [6:0]  opcode;
  logic [2:0]  func3;     // Also memory/AMO width
  logic [11:0] csr_addr;
  logic        is_rs1;
  logic        is_rs2;
  logic        is_rd;
  logic        is_fs1;
  logic        is_fd;
  logic        is_vfp;
  logic        is_load;
  logic        is_store;

  assign opcode   = instruction_i[6:0];
  assign func3    = instruction_i[14:12];
  assign csr_addr = instruction_i[31:20];

  always_comb begin
    is_accel_o = 1'b0;
    is_rs1     = 1'b0;
    is_rs2     = 1'b0;
    is_rd      = 1'b0;
    is_fs1     = 1'b0;
    is_fd      = 1'b0;
    is_vfp     = 1'b0;
    is_load    = (opcode == accel_pkg::OPCODE_LOAD_FP);
    is_store   = (opcode == accel_pkg::OPCODE_STORE_FP);

    case (opcode)
      accel_pkg::OPCODE_VEC: begin
        is_accel_o = 1'b1;
        case (func3)
          accel_pkg::OPIVV, accel_pkg::OPIVI: begin
          end  // Vector or immediate operands only
          accel_pkg::OPFVV: begin
            is_fd  = (instruction_i[31:26] == 6'b010_000);  // VFWUNARY0
            is_vfp = 1'b1;
          end
          accel_pkg::OPMVV: is_rd = (instruction_i[31:26] == 6'b010_000);  // VWXUNARY0
          accel_pkg::OPIVX, accel_pkg::OPMVX: is_rs1 = 1'b1;
          accel_pkg::OPFVF: begin
            is_fs1 = 1'b1;
            is_vfp = 1'b1;
          end
          accel_pkg::OPCFG: begin
            is_rs1 = (instruction_i[31:30] != 2'b11);        // Not vsetivli
            is_rs2 = (instruction_i[31:25] == 7'b100_0000);  // vsetvl
            is_rd  = 1'b1;
          end
        endcase
      end

      // Vector loads and stores share the FP major opcodes
      accel_pkg::OPCODE_LOAD_FP, accel_pkg::OPCODE_STORE_FP: begin
        case ({instruction_i[28], func3})  // {mew, width}
          4'b0000, 4'b0101, 4'b0110, 4'b0111,
          4'b1000, 4'b1101, 4'b1110, 4'b1111: begin
            is_accel_o = 1'b1;
            is_rs1     = 1'b1;                             // Base address
            is_rs2     = (instruction_i[27:26] == 2'b10);  // Stride
          end
          default: is_accel_o = 1'b0;  // Scalar FP access
        endcase
      end

      accel_pkg::OPCODE_AMO: begin
        case (func3)
          3'b000, 3'b101, 3'b110, 3'b111: begin  // VAMO*EI8..64
            is_accel_o = 1'b1;
            is_rs1     = 1'b1;
          end
          default: is_accel_o = 1'b0;
        endcase
      end

      // CSR accesses, only vector CSRs go out
      accel_pkg::OPCODE_SYSTEM: begin
        if (func3 != 3'b000 && func3 != 3'b100) begin
          is_accel_o = accel_pkg::is_vector_csr(csr_addr);
          is_rs1     = is_accel_o;
          is_rs2     = is_accel_o;
          is_rd      = is_accel_o;
        end
      end

      default: is_accel_o = 1'b0;
    endcase
  end

  // Operation class, stores take priority over loads
  always_comb begin
    if (is_store)    op_o = accel_pkg::ACCEL_OP_STORE;
    else if (is_load) op_o = accel_pkg::ACCEL_OP_LOAD;
    else if (is_fs1)  op_o = accel_pkg::ACCEL_OP_FS1;
    else if (is_fd)   op_o = accel_pkg::ACCEL_OP_FD;
    else              op_o = accel_pkg::ACCEL_OP;
  end

  assign illegal_instr_o = is_accel_o && ((vs_i == accel_pkg::XS_OFF) ||
                                          (is_vfp && fs_i == accel_pkg::XS_OFF));

  assign vfp_o     = is_vfp;
  assign use_rs1_o = is_rs1;  // Integer sources only
  assign use_rs2_o = is_rs2;
  assign use_rd_o  = is_rd;   // FD gets no write-back
  assign rs1_o     = (is_rs1 || is_fs1) ? instruction_i[19:15] : '0;
  assign rs2_o     = is_rs2 ? instruction_i[24:20] : '0;
  assign rd_o      = (is_rd || is_fd) ? instruction_i[11:7] : '0;

endmodule

// File: src/scalar_regfile.sv
// Integer register file, 2 async reads and 1 sync write, x0 hardwired to zero
`timescale 1ns/1ns

module scalar_regfile (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [accel_pkg::REG_ADDR_SIZE-1:0] raddr_a_i,
  input  logic [accel_pkg::REG_ADDR_SIZE-1:0] raddr_b_i,
  output logic [accel_pkg::XLEN-1:0]          rdata_a_o,
  output logic [accel_pkg::XLEN-1:0]          rdata_b_o,
  input  logic                                we_i,
  input  logic [accel_pkg::REG_ADDR_SIZE-1:0] waddr_i,
  input  logic [accel_pkg::XLEN-1:0]          wdata_i
);

  logic [accel_pkg::XLEN-1:0] regs_q [2**accel_pkg::REG_ADDR_SIZE];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 2**accel_pkg::REG_ADDR_SIZE; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin  // x0 never written
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// File: src/accel_fifo.sv
// Synchronous circular-buffer FIFO, payload type set by parameter
`timescale 1ns/1ns

module accel_fifo #(
  parameter type dtype_t = logic,
  parameter int  DEPTH   = 4
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   push_i,
  input  dtype_t data_i,
  output logic   full_o,
  input  logic   pop_i,
  output dtype_t data_o,
  output logic   empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  dtype_t           mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];  // Head, stable until popped
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  a_no_overflow:  assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

// File: src/accel_dispatcher.sv
// Per-instruction dispatch control
// Reads operands, queues accelerator requests, writes back scalar results, flags exceptions
`timescale 1ns/1ns

module accel_dispatcher (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                instr_valid_i,
  input  logic [31:0]                         instr_i,
  input  logic [accel_pkg::XLEN-1:0]          pc_i,
  output logic                                instr_done_o,
  input  logic                                is_accel_i,
  input  logic                                illegal_instr_i,
  input  logic                                vfp_i,
  input  accel_pkg::accel_op_t                op_i,
  input  logic [accel_pkg::REG_ADDR_SIZE-1:0] rd_i,
  input  logic                                use_rs1_i,
  input  logic                                use_rs2_i,
  input  logic                                use_rd_i,
  input  logic [accel_pkg::XLEN-1:0]          rs1_data_i,
  input  logic [accel_pkg::XLEN-1:0]          rs2_data_i,
  output logic                                rf_we_o,
  output logic [accel_pkg::REG_ADDR_SIZE-1:0] rf_waddr_o,
  output logic [accel_pkg::XLEN-1:0]          rf_wdata_o,
  output logic                                req_push_o,
  output accel_pkg::accel_req_t               req_data_o,
  input  logic                                req_full_i,
  output logic                                resp_pop_o,
  input  logic [accel_pkg::XLEN-1:0]          resp_data_i,
  input  logic                                resp_empty_i,
  output logic                                exc_valid_o,
  output logic [accel_pkg::XLEN-1:0]          exc_pc_o,
  output logic [31:0]                         exc_instr_o
);

  typedef enum logic [1:0] {S_IDLE, S_PUSH, S_WAIT_RES} state_e;

  state_e state_q;
  state_e state_d;

  always_ff @(posedge clk_i) begin
    if (rst_i) state_q <= S_IDLE;
    else       state_q <= state_d;
  end

  always_comb begin
    state_d      = state_q;
    instr_done_o = 1'b0;
    req_push_o   = 1'b0;
    resp_pop_o   = 1'b0;
    rf_we_o      = 1'b0;
    exc_valid_o  = 1'b0;
    case (state_q)
      S_IDLE: if (instr_valid_i) state_d = S_PUSH;  // Decoder settles on held word
      S_PUSH: begin
        if (!is_accel_i) begin
          instr_done_o = 1'b1;  // Scalar pipeline's business
          state_d      = S_IDLE;
        end else if (illegal_instr_i) begin
          exc_valid_o  = 1'b1;
          instr_done_o = 1'b1;
          state_d      = S_IDLE;
        end else if (!req_full_i) begin
          req_push_o = 1'b1;
          if (use_rd_i) begin
            state_d = S_WAIT_RES;
          end else begin
            instr_done_o = 1'b1;
            state_d      = S_IDLE;
          end
        end
      end
      S_WAIT_RES: begin
        if (!resp_empty_i) begin  // Result ready, write back and retire
          resp_pop_o   = 1'b1;
          rf_we_o      = 1'b1;
          instr_done_o = 1'b1;
          state_d      = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  // Request payload, unused operands forced to zero
  always_comb begin
    req_data_o.instr = instr_i;
    req_data_o.op    = op_i;
    req_data_o.vfp   = vfp_i;
    req_data_o.rs1   = use_rs1_i ? rs1_data_i : '0;
    req_data_o.rs2   = use_rs2_i ? rs2_data_i : '0;
    req_data_o.rd    = rd_i;
  end

  assign rf_waddr_o  = rd_i;
  assign rf_wdata_o  = resp_data_i;
  assign exc_pc_o    = pc_i;
  assign exc_instr_o = instr_i;

  // Accelerator only answers requests that name rd
  a_resp_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    !resp_empty_i |-> state_q == S_WAIT_RES);

endmodule

// File: src/accel_dispatch_top.sv
// Vector dispatch front top level
// Fetch, decode, operand read and request/response queues to the vector accelerator
`timescale 1ns/1ns

module accel_dispatch_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  accel_pkg::xs_t                      fs_i,
  input  accel_pkg::xs_t                      vs_i,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic [accel_pkg::XLEN-1:0]          wb_adr_o,
  input  logic [31:0]                         wb_dat_i,
  input  logic                                wb_ack_i,
  output logic                                acc_req_valid_o,
  input  logic                                acc_req_ready_i,
  output logic [31:0]                         acc_req_instr_o,
  output accel_pkg::accel_op_t                acc_req_op_o,
  output logic                                acc_req_vfp_o,
  output logic [accel_pkg::XLEN-1:0]          acc_req_rs1_o,
  output logic [accel_pkg::XLEN-1:0]          acc_req_rs2_o,
  output logic [accel_pkg::REG_ADDR_SIZE-1:0] acc_req_rd_o,
  input  logic                                acc_resp_valid_i,
  output logic                                acc_resp_ready_o,
  input  logic [accel_pkg::XLEN-1:0]          acc_resp_result_i,
  output logic                                exc_valid_o,
  output logic [accel_pkg::XLEN-1:0]          exc_pc_o,
  output logic [31:0]                         exc_instr_o
);

  logic                                instr_valid;
  logic [31:0]                         instr;
  logic [accel_pkg::XLEN-1:0]          pc;
  logic                                instr_done;
  logic                                is_accel;
  logic                                illegal_instr;
  logic                                vfp;
  accel_pkg::accel_op_t                op;
  logic [accel_pkg::REG_ADDR_SIZE-1:0] rs1_idx;
  logic [accel_pkg::REG_ADDR_SIZE-1:0] rs2_idx;
  logic [accel_pkg::REG_ADDR_SIZE-1:0] rd_idx;
  logic                                use_rs1;
  logic                                use_rs2;
  logic                                use_rd;
  logic [accel_pkg::XLEN-1:0]          rs1_data;
  logic [accel_pkg::XLEN-1:0]          rs2_data;
  logic                                rf_we;
  logic [accel_pkg::REG_ADDR_SIZE-1:0] rf_waddr;
  logic [accel_pkg::XLEN-1:0]          rf_wdata;
  logic                                req_push;
  accel_pkg::accel_req_t               req_in;
  accel_pkg::accel_req_t               req_head;   // Request FIFO head
  logic                                req_full;
  logic                                req_empty;
  logic                                resp_pop;
  logic [accel_pkg::XLEN-1:0]          resp_data;
  logic                                resp_full;
  logic                                resp_empty;

  wb_fetch i_fetch (
    .clk_i, .rst_i, .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_dat_i, .wb_ack_i,
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .pc_o          (pc),
    .instr_done_i  (instr_done)
  );

  accel_first_pass_decoder i_decoder (
    .instruction_i (instr),
    .fs_i, .vs_i,
    .is_accel_o (is_accel), .illegal_instr_o (illegal_instr), .vfp_o (vfp), .op_o (op),
    .rs1_o (rs1_idx), .rs2_o (rs2_idx), .rd_o (rd_idx),
    .use_rs1_o (use_rs1), .use_rs2_o (use_rs2), .use_rd_o (use_rd)
  );

  // Read indices come straight from the decoder fields
  scalar_regfile i_regfile (
    .clk_i, .rst_i,
    .raddr_a_i (rs1_idx), .raddr_b_i (rs2_idx),
    .rdata_a_o (rs1_data), .rdata_b_o (rs2_data),
    .we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (rf_wdata)
  );

  accel_dispatcher i_dispatcher (
    .clk_i, .rst_i,
    .instr_valid_i (instr_valid), .instr_i (instr), .pc_i (pc), .instr_done_o (instr_done),
    .is_accel_i (is_accel), .illegal_instr_i (illegal_instr), .vfp_i (vfp), .op_i (op),
    .rd_i (rd_idx), .use_rs1_i (use_rs1), .use_rs2_i (use_rs2), .use_rd_i (use_rd),
    .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .rf_we_o (rf_we), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata),
    .req_push_o (req_push), .req_data_o (req_in), .req_full_i (req_full),
    .resp_pop_o (resp_pop), .resp_data_i (resp_data), .resp_empty_i (resp_empty),
    .exc_valid_o, .exc_pc_o, .exc_instr_o
  );

  accel_fifo #(.dtype_t(accel_pkg::accel_req_t), .DEPTH(accel_pkg::REQ_DEPTH)) i_req_fifo (
    .clk_i, .rst_i,
    .push_i (req_push), .data_i (req_in), .full_o (req_full),
    .pop_i  (acc_req_valid_o && acc_req_ready_i),  // Valid/ready handshake
    .data_o (req_head), .empty_o (req_empty)
  );

  accel_fifo #(.dtype_t(logic [accel_pkg::XLEN-1:0]), .DEPTH(accel_pkg::RESP_DEPTH)) i_resp_fifo (
    .clk_i, .rst_i,
    .push_i (acc_resp_valid_i && acc_resp_ready_o), .data_i (acc_resp_result_i),
    .full_o (resp_full),
    .pop_i  (resp_pop), .data_o (resp_data), .empty_o (resp_empty)
  );

  assign acc_req_valid_o  = !req_empty;
  assign acc_req_instr_o  = req_head.instr;
  assign acc_req_op_o     = req_head.op;
  assign acc_req_vfp_o    = req_head.vfp;
  assign acc_req_rs1_o    = req_head.rs1;
  assign acc_req_rs2_o    = req_head.rs2;
  assign acc_req_rd_o     = req_head.rd;
  assign acc_resp_ready_o = !resp_full;

endmodule

// File: test/tb_accel_dispatch.sv
// Testbench for the vector dispatch front
// Memory and accelerator models, program table with expected requests and exceptions
`timescale 1ns/1ns

module tb_accel_dispatch;

  localparam int          N_ENTRIES = 16;
  localparam logic [31:0] RES_KEY   = 32'h5A5A_C3C3;  // Model result is rs1 ^ RES_KEY
  localparam logic [31:0] NOP_WORD  = 32'h0000_0013;  // addi x0, x0, 0

  logic clk_i = 1'b0;
  logic rst_i = 1'b1;
  accel_pkg::xs_t fs_i = accel_pkg::XS_DIRTY;
  accel_pkg::xs_t vs_i = accel_pkg::XS_DIRTY;
  logic wb_cyc_o, wb_stb_o, wb_ack_i = 1'b0;
  logic [31:0] wb_adr_o, wb_dat_i = '0;
  logic acc_req_valid_o, acc_req_ready_i = 1'b0, acc_req_vfp_o;
  logic [31:0] acc_req_instr_o, acc_req_rs1_o, acc_req_rs2_o;
  accel_pkg::accel_op_t acc_req_op_o;
  logic [4:0] acc_req_rd_o;
  logic acc_resp_valid_i = 1'b0, acc_resp_ready_o;
  logic [31:0] acc_resp_result_i = '0;
  logic exc_valid_o;
  logic [31:0] exc_pc_o, exc_instr_o;

  // Program table, one row per word address
  logic [31:0]          prog_word [N_ENTRIES];
  accel_pkg::xs_t       prog_vs   [N_ENTRIES];
  accel_pkg::xs_t       prog_fs   [N_ENTRIES];
  accel_pkg::accel_op_t prog_op   [N_ENTRIES];
  logic                 prog_vfp  [N_ENTRIES];
  logic [4:0]           prog_rd   [N_ENTRIES];
  int                   prog_rs1  [N_ENTRIES];  // Source register, -1 when unused
  int                   prog_rs2  [N_ENTRIES];
  logic                 prog_wb   [N_ENTRIES];  // Scalar result written back

  logic [31:0] ref_regs [32];
  int          exp_req_q [$];
  int          exp_exc_q [$];
  logic [15:0] lfsr = 16'd35;
  int          n_fill;

  accel_dispatch_top UUT (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // Galois step
    end
    return r;
  endfunction

  function automatic logic [31:0] vec_word(logic [5:0] f6, logic [4:0] vs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    return {f6, 1'b1, vs2, rs1, f3, rd, accel_pkg::OPCODE_VEC};
  endfunction

  function automatic logic [31:0] csr_word(logic [11:0] csr, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd);
    return {csr, rs1, f3, rd, accel_pkg::OPCODE_SYSTEM};
  endfunction

  task automatic add_entry(logic [31:0] word, accel_pkg::xs_t vs, accel_pkg::xs_t fs, int kind,
                           accel_pkg::accel_op_t op, logic vfp, logic [4:0] rd, int rs1, int rs2,
                           logic wb);
    prog_word[n_fill] = word;
    prog_vs[n_fill]   = vs;
    prog_fs[n_fill]   = fs;
    prog_op[n_fill]   = op;
    prog_vfp[n_fill]  = vfp;
    prog_rd[n_fill]   = rd;
    prog_rs1[n_fill]  = rs1;
    prog_rs2[n_fill]  = rs2;
    prog_wb[n_fill]   = wb;
    if (kind == 1) exp_req_q.push_back(n_fill);  // Request expected
    if (kind == 2) exp_exc_q.push_back(n_fill);  // Exception expected, 0 means neither
    n_fill++;
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    a_value: assert (exp == act) else begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic stop_run(string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] reg_value(int idx);
    return (idx < 0) ? 32'h0 : ref_regs[idx];
  endfunction

  initial begin
    accel_pkg::xs_t on;
    accel_pkg::xs_t off;
    on     = accel_pkg::XS_DIRTY;
    off    = accel_pkg::XS_OFF;
    n_fill = 0;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    // CSR reads load x1..x3 first
    add_entry(csr_word(12'hC20, 5'd0, 3'b010, 5'd1), on, on, 1, accel_pkg::ACCEL_OP, 0, 1, 0, 0, 1);
    add_entry(csr_word(12'hC21, 5'd1, 3'b010, 5'd2), on, on, 1, accel_pkg::ACCEL_OP, 0, 2, 1, 1, 1);
    add_entry(csr_word(12'h009, 5'd2, 3'b011, 5'd3), on, on, 1, accel_pkg::ACCEL_OP, 0, 3, 2, 9, 1);
    add_entry(vec_word(6'd0, 5'd8, 5'd1, accel_pkg::OPIVX, 5'd4), on, on, 1,
              accel_pkg::ACCEL_OP, 0, 0, 1, -1, 0);                          // vadd.vx
    add_entry({6'b000_000, 1'b1, 5'd0, 5'd3, 3'b110, 5'd2, accel_pkg::OPCODE_LOAD_FP}, on, on, 1,
              accel_pkg::ACCEL_OP_LOAD, 0, 0, 3, -1, 0);                     // vle32.v
    add_entry({6'b000_010, 1'b1, 5'd2, 5'd1, 3'b110, 5'd5, accel_pkg::OPCODE_STORE_FP}, on, on, 1,
              accel_pkg::ACCEL_OP_STORE, 0, 0, 1, 2, 0);                     // vsse32.v
    add_entry({5'd0, 2'b11, 5'd9, 5'd3, 3'b110, 5'd7, accel_pkg::OPCODE_AMO}, on, on, 1,
              accel_pkg::ACCEL_OP, 0, 0, 3, -1, 0);                          // vamoaddei32
    add_entry({7'b100_0000, 5'd1, 5'd2, 3'b111, 5'd4, accel_pkg::OPCODE_VEC}, on, on, 1,
              accel_pkg::ACCEL_OP, 0, 4, 2, 1, 1);                           // vsetvl x4
    add_entry(vec_word(6'b010_000, 5'd3, 5'd0, accel_pkg::OPMVV, 5'd5), on, on, 1,
              accel_pkg::ACCEL_OP, 0, 5, -1, -1, 1);                         // vmv.x.s x5
    add_entry(vec_word(6'd0, 5'd7, 5'd2, accel_pkg::OPFVF, 5'd6), on, on, 1,
              accel_pkg::ACCEL_OP_FS1, 1, 0, -1, -1, 0);                     // vfadd.vf
    add_entry(vec_word(6'd0, 5'd8, 5'd4, accel_pkg::OPIVX, 5'd9), on, on, 1,
              accel_pkg::ACCEL_OP, 0, 0, 4, -1, 0);                          // Reads vsetvl result
    add_entry(32'h0010_0293, on, on, 0, accel_pkg::ACCEL_OP, 0, 0, -1, -1, 0);  // addi
    add_entry(32'h0000_0463, on, on, 0, accel_pkg::ACCEL_OP, 0, 0, -1, -1, 0);  // beq
    add_entry(vec_word(6'd0, 5'd2, 5'd1, accel_pkg::OPIVX, 5'd1), off, on, 2,
              accel_pkg::ACCEL_OP, 0, 0, -1, -1, 0);                         // Vector unit off
    add_entry(vec_word(6'd0, 5'd7, 5'd2, accel_pkg::OPFVF, 5'd6), on, off, 2,
              accel_pkg::ACCEL_OP, 0, 0, -1, -1, 0);                         // FP off, vfp op
    add_entry(vec_word(6'd0, 5'd8, 5'd5, accel_pkg::OPIVX, 5'd3), on, off, 1,
              accel_pkg::ACCEL_OP, 0, 0, 5, -1, 0);                          // FP off, integer op
    repeat (3) @(posedge clk_i);
    #1 rst_i = 1'b0;
    wait (exp_req_q.size() == 0 && exp_exc_q.size() == 0 && wb_adr_o >= 32'(N_ENTRIES * 4));
    repeat (20) @(posedge clk_i);  // Filler words must stay silent
    $display("TEST PASS");
    $finish;
  end

  initial begin
    #(N_ENTRIES * 200 * 10);
    stop_run("Timeout: the program did not complete in time");
  end

  // Wishbone slave, LFSR wait states, ack held one cycle
  initial begin
    logic [31:0] delay;
    logic        pending;
    int          widx;
    pending = 1'b0;
    delay   = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (wb_cyc_o !== wb_stb_o) stop_run("Wishbone cyc and stb are not driven together");
      widx = int'(wb_adr_o >> 2);
      if (widx < N_ENTRIES) begin
        vs_i = prog_vs[widx];  // Status follows the word in flight
        fs_i = prog_fs[widx];
      end
      if (wb_ack_i) begin
        wb_ack_i = 1'b0;
        pending  = 1'b0;
      end else if (wb_stb_o && !rst_i) begin
        if (!pending) begin
          pending = 1'b1;
          delay   = take_bits(2);
        end
        if (delay == 0) begin
          wb_ack_i = 1'b1;
          wb_dat_i = (widx < N_ENTRIES) ? prog_word[widx] : NOP_WORD;
        end else begin
          delay = delay - 1;
        end
      end
    end
  end

  // Accelerator model, checks sampled mid-cycle
  initial begin
    logic        answer;
    logic        prev_stall;
    logic [31:0] prev_instr, prev_rs1, prev_rs2, prev_ctrl, result;
    int          e;
    answer     = 1'b0;
    prev_stall = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!rst_i) begin
        if (acc_resp_valid_i && !acc_resp_ready_o) begin
          stop_run("Result offered while the response FIFO was not ready");
        end
        if (prev_stall) begin
          if (!acc_req_valid_o) stop_run("Request valid dropped while ready was low");
          check_value("stall_instr", prev_instr, acc_req_instr_o);
          check_value("stall_rs1", prev_rs1, acc_req_rs1_o);
          check_value("stall_rs2", prev_rs2, acc_req_rs2_o);
          check_value("stall_ctrl", prev_ctrl,
                      32'({acc_req_op_o, acc_req_vfp_o, acc_req_rd_o}));
        end
        prev_stall = acc_req_valid_o && !acc_req_ready_i;
        prev_instr = acc_req_instr_o;
        prev_rs1   = acc_req_rs1_o;
        prev_rs2   = acc_req_rs2_o;
        prev_ctrl  = 32'({acc_req_op_o, acc_req_vfp_o, acc_req_rd_o});  // op, vfp, rd
        if (acc_req_valid_o && acc_req_ready_i) begin
          if (exp_req_q.size() == 0) stop_run("Request accepted when none was expected");
          e = exp_req_q.pop_front();
          check_value("req_instr", prog_word[e], acc_req_instr_o);
          check_value("req_op", 32'(prog_op[e]), 32'(acc_req_op_o));
          check_value("req_vfp", 32'(prog_vfp[e]), 32'(acc_req_vfp_o));
          check_value("req_rd", 32'(prog_rd[e]), 32'(acc_req_rd_o));
          check_value("req_rs1", reg_value(prog_rs1[e]), acc_req_rs1_o);
          check_value("req_rs2", reg_value(prog_rs2[e]), acc_req_rs2_o);
          if (prog_wb[e]) begin
            result = acc_req_rs1_o ^ RES_KEY;
            answer = 1'b1;
            if (prog_rd[e] != 0) ref_regs[prog_rd[e]] = reg_value(prog_rs1[e]) ^ RES_KEY;
          end
        end
        if (exc_valid_o) begin
          if (exp_exc_q.size() == 0) stop_run("Exception raised when none was expected");
          e = exp_exc_q.pop_front();
          check_value("exc_pc", 32'(e * 4), exc_pc_o);
          check_value("exc_instr", prog_word[e], exc_instr_o);
        end
      end
      @(posedge clk_i);
      #1;
      acc_resp_valid_i  = answer;
      acc_resp_result_i = answer ? result : '0;
      answer            = 1'b0;
      acc_req_ready_i   = !rst_i && (take_bits(2) != 0);  // Back-pressure one time in four
    end
  end

endmodule

// File: all.f
src/accel_pkg.sv
src/wb_fetch.sv
src/accel_first_pass_decoder.sv
src/scalar_regfile.sv
src/accel_fifo.sv
src/accel_dispatcher.sv
src/accel_dispatch_top.sv
test/tb_accel_dispatch.sv

// File: Makefile
SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_accel_dispatch: all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_accel_dispatch -f all.f

run: obj_dir/Vtb_accel_dispatch
	./obj_dir/Vtb_accel_dispatch | grep "TEST PASS"

clean:
	rm -rf obj_dir
